// File: Bender.yml
package:
  name: pipe_core

sources:
  - logic/corePkg.sv
  - logic/idExIf.sv
  - logic/instDecoder.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/decodeStage.sv
  - logic/executeStage.sv
  - logic/pipeCore.sv
  - target: test
    files:
      - dv/pipeCore_asserts.sv
      - dv/pipeCoreTb.sv

// File: compile.f
logic/corePkg.sv
logic/idExIf.sv
logic/instDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/pipeCore.sv
dv/pipeCore_asserts.sv
dv/pipeCoreTb.sv

// File: dv/pipeCoreTb.sv
`timescale 1ns/1ps

module pipeCoreTb import corePkg::*; ();

    localparam int RomWords = 256;

    logic  iClk;
    logic  iRst_n;
    word_t instAddr;
    word_t inst;
    logic  memWrite;
    word_t memAddr;
    word_t memWrData;

    word_t rom [RomWords];
    word_t prog [$];
    word_t model [32];
    word_t expAddr [$];
    word_t expData [$];
    int    expCycle [$];

    int    seed;
    int    valueErrors;
    int    otherErrors;
    int    cycleBudget;
    int    storeOffset;

    pipeCore #(
        .ResetPc (32'h0)
    ) DUT (
        .iClk      (iClk),
        .iRst_n    (iRst_n),
        .instAddr  (instAddr),
        .inst      (inst),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWrData (memWrData)
    );

    initial begin
        iClk = 1'b0;
    end

    always #50 iClk = ~iClk;

    // Instruction ROM answers on the falling edge
    always @(negedge iClk) begin
        inst <= rom[instAddr[9:2]];
    end

    function automatic word_t encodeR(funct_t fn, regId_t rs, regId_t rt, regId_t rd,
                                      shamt_t sh);
        return {OpRType, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encodeI(opcode_t op, regId_t rs, regId_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic loadConst(regId_t rd, word_t value);
        prog.push_back(encodeI(OpLui, 5'd0, rd, value[31:16]));
        prog.push_back(encodeI(OpOri, rd, rd, value[15:0]));
    endtask

    // Store to the next free slot off r0
    task automatic storeReg(regId_t rt);
        prog.push_back(encodeI(OpSw, 5'd0, rt, 16'(storeOffset)));
        storeOffset += 4;
    endtask

    task automatic addNops(int n);
        repeat (n) prog.push_back('0);
    endtask

    // Program-order register model that predicts every store
    task automatic predict();
        word_t  w;
        word_t  a;
        word_t  b;
        word_t  simm;
        word_t  res;
        regId_t dest;
        logic   wr;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        foreach (prog[i]) begin
            w    = prog[i];
            a    = model[w[25:21]];
            b    = model[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            res  = '0;
            dest = w[20:16];
            wr   = 1'b1;
            case (w[31:26])
                OpRType: begin
                    dest = w[15:11];
                    case (w[5:0])
                        FunctAdd, FunctAddu: res = a + b;
                        FunctSub, FunctSubu: res = a - b;
                        FunctAnd:  res = a & b;
                        FunctOr:   res = a | b;
                        FunctXor:  res = a ^ b;
                        FunctNor:  res = ~(a | b);
                        FunctSlt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                        FunctSll:  res = b << w[10:6];
                        FunctSrl:  res = b >> w[10:6];
                        FunctSra:  res = $signed(b) >>> w[10:6];
                        FunctSllv: res = b << a[4:0];
                        FunctSrlv: res = b >> a[4:0];
                        FunctSrav: res = $signed(b) >>> a[4:0];
                        default:   wr = 1'b0;
                    endcase
                end
                OpAddi, OpAddiu: res = a + simm;
                OpAndi:  res = a & {16'h0, w[15:0]};
                OpOri:   res = a | {16'h0, w[15:0]};
                OpSlti:  res = ($signed(a) < $signed(simm)) ? 1 : 0;
                OpSltiu: res = (a < simm) ? 1 : 0;
                OpLui:   res = {w[15:0], 16'h0};
                OpSw: begin
                    wr = 1'b0;
                    expAddr.push_back(a + simm);
                    expData.push_back(b);
                    // Store shows 3 cycles after its fetch at the word index
                    expCycle.push_back(i + 3);
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dest != 0)) begin
                model[dest] = res;
            end
        end
    endtask

    task automatic runProgram(string testName);
        int cyc;
        int storeNo;
        expAddr.delete();
        expData.delete();
        expCycle.delete();
        foreach (rom[i]) begin
            rom[i] = '0;
        end
        foreach (prog[i]) begin
            rom[i] = prog[i];
        end
        predict();
        cycleBudget += prog.size() + 40;
        @(negedge iClk);
        iRst_n = 1'b0;
        repeat (16) @(negedge iClk);
        iRst_n  = 1'b1;
        cyc     = 0;
        storeNo = 0;
        while ((expAddr.size() > 0) && (cyc < prog.size() + 8)) begin
            if (instAddr !== 32'(4 * cyc)) begin
                $display("** Error [%s] instAddr in cycle %0d: expected %h, actual %h",
                         testName, cyc, 32'(4 * cyc), instAddr);
                valueErrors++;
            end
            if (memWrite === 1'b1) begin
                if (cyc != expCycle[0]) begin
                    $display("** Error [%s] store %0d cycle: expected %0d, actual %0d",
                             testName, storeNo, expCycle[0], cyc);
                    valueErrors++;
                end
                if (memAddr !== expAddr[0]) begin
                    $display("** Error [%s] store %0d address: expected %h, actual %h",
                             testName, storeNo, expAddr[0], memAddr);
                    valueErrors++;
                end
                if (memWrData !== expData[0]) begin
                    $display("** Error [%s] store %0d data: expected %h, actual %h",
                             testName, storeNo, expData[0], memWrData);
                    valueErrors++;
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                void'(expCycle.pop_front());
                storeNo++;
            end else if (memWrite !== 1'b0) begin
                $display("[%s] memWrite is unknown in cycle %0d", testName, cyc);
                otherErrors++;
            end
            @(negedge iClk);
            cyc++;
        end
        if (expAddr.size() > 0) begin
            $display("[%s] %0d predicted stores never appeared", testName, expAddr.size());
            otherErrors++;
        end
        prog.delete();
    endtask

    task automatic testResetFetch();
        // First instruction is a store so its timing is exact
        prog.push_back(encodeI(OpSw, 5'd0, 5'd0, 16'h0010));
        loadConst(5'd2, $random(seed));
        prog.push_back(encodeI(OpSw, 5'd0, 5'd2, 16'h0014));
        runProgram("resetFetch");
    endtask

    task automatic testRType();
        funct_t ops [9] = '{FunctAdd, FunctAddu, FunctSub, FunctSubu, FunctAnd,
                            FunctOr, FunctXor, FunctNor, FunctSlt};
        word_t  x;
        for (int round = 0; round < 3; round++) begin
            x = $random(seed);
            // Equal operands in round 1 and a negative rs in round 2
            loadConst(5'd1, (round == 2) ? (x | 32'h8000_0000) : x);
            loadConst(5'd2, (round == 1) ? x : word_t'($random(seed)));
            foreach (ops[k]) begin
                prog.push_back(encodeR(ops[k], 5'd1, 5'd2, 5'd3, 5'd0));
                storeReg(5'd3);
            end
        end
        runProgram("rType");
    endtask

    task automatic testIType();
        opcode_t     ops [7] = '{OpAddi, OpAddiu, OpAndi, OpOri, OpSlti, OpSltiu, OpLui};
        logic [15:0] imms [4];
        for (int round = 0; round < 2; round++) begin
            imms = '{16'($random(seed)), 16'h8000, 16'hfff0, 16'h7fff};
            loadConst(5'd1, (round == 1) ? (32'h8000_0000 | $random(seed)) : $random(seed));
            foreach (imms[j]) begin
                foreach (ops[k]) begin
                    prog.push_back(encodeI(ops[k], 5'd1, 5'd4, imms[j]));
                    storeReg(5'd4);
                end
            end
        end
        runProgram("iType");
    endtask

    task automatic testShifts();
        shamt_t amounts [3];
        word_t  varAmounts [3];
        amounts    = '{5'd0, 5'd31, shamt_t'($random(seed))};
        varAmounts = '{32'd0, 32'd31, 32'h20 | ($random(seed) & 32'h1f)};
        // Negative input so sra fills with ones
        loadConst(5'd1, 32'h8000_0000 | $random(seed));
        foreach (amounts[j]) begin
            prog.push_back(encodeR(FunctSll, 5'd0, 5'd1, 5'd5, amounts[j]));
            storeReg(5'd5);
            prog.push_back(encodeR(FunctSrl, 5'd0, 5'd1, 5'd5, amounts[j]));
            storeReg(5'd5);
            prog.push_back(encodeR(FunctSra, 5'd0, 5'd1, 5'd5, amounts[j]));
            storeReg(5'd5);
        end
        foreach (varAmounts[j]) begin
            loadConst(5'd2, varAmounts[j]);
            prog.push_back(encodeR(FunctSllv, 5'd2, 5'd1, 5'd6, 5'd0));
            storeReg(5'd6);
            prog.push_back(encodeR(FunctSrlv, 5'd2, 5'd1, 5'd6, 5'd0));
            storeReg(5'd6);
            prog.push_back(encodeR(FunctSrav, 5'd2, 5'd1, 5'd6, 5'd0));
            storeReg(5'd6);
        end
        runProgram("shifts");
    endtask

    task automatic testHazards();
        loadConst(5'd1, $random(seed));
        loadConst(5'd2, $random(seed));
        // Distance 1 on rs, rt and store data
        prog.push_back(encodeR(FunctAddu, 5'd1, 5'd2, 5'd3, 5'd0));
        prog.push_back(encodeR(FunctAddu, 5'd3, 5'd1, 5'd4, 5'd0));
        prog.push_back(encodeR(FunctXor, 5'd2, 5'd4, 5'd5, 5'd0));
        storeReg(5'd5);
        // Distance 2
        prog.push_back(encodeR(FunctAddu, 5'd1, 5'd2, 5'd6, 5'd0));
        addNops(1);
        prog.push_back(encodeR(FunctSubu, 5'd6, 5'd1, 5'd7, 5'd0));
        addNops(1);
        prog.push_back(encodeR(FunctOr, 5'd2, 5'd7, 5'd8, 5'd0));
        addNops(1);
        storeReg(5'd8);
        // Distance 3 goes through the register file write-through
        prog.push_back(encodeR(FunctAddu, 5'd2, 5'd1, 5'd9, 5'd0));
        addNops(2);
        prog.push_back(encodeR(FunctXor, 5'd9, 5'd1, 5'd10, 5'd0));
        addNops(2);
        prog.push_back(encodeR(FunctNor, 5'd1, 5'd10, 5'd11, 5'd0));
        addNops(2);
        storeReg(5'd11);
        // Fresh base register with a negative offset
        prog.push_back(encodeI(OpAddiu, 5'd0, 5'd12, 16'h0100));
        prog.push_back(encodeI(OpSw, 5'd12, 5'd11, 16'hfffc));
        // r0 writes are dropped and never forwarded
        prog.push_back(encodeI(OpAddiu, 5'd1, 5'd0, 16'h0005));
        storeReg(5'd0);
        prog.push_back(encodeR(FunctAddu, 5'd0, 5'd2, 5'd13, 5'd0));
        storeReg(5'd13);
        // Unknown opcode and unknown funct aimed at r1
        prog.push_back(encodeI(6'h3f, 5'd1, 5'd1, 16'h1234));
        prog.push_back(encodeR(6'h3f, 5'd1, 5'd2, 5'd1, 5'd0));
        storeReg(5'd1);
        runProgram("hazards");
    endtask

    initial begin
        seed        = 32'he282_20be;
        iRst_n      = 1'b0;
        inst        = '0;
        valueErrors = 0;
        otherErrors = 0;
        cycleBudget = 0;
        storeOffset = 0;
        testResetFetch();
        testRType();
        testIType();
        testShifts();
        testHazards();
        $display("Checks done: %0d value errors, %0d other errors, %0d assertion failures",
                 valueErrors, otherErrors, DUT.uAsserts.failCount);
        if ((valueErrors == 0) && (otherErrors == 0) && (DUT.uAsserts.failCount == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Budget grows as each test registers its program length
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= cycleBudget) begin
            @(negedge iClk);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles, the tests did not finish", cycles);
        $display("Checks done: %0d value errors, %0d other errors, %0d assertion failures",
                 valueErrors, otherErrors, DUT.uAsserts.failCount);
        $display("Test failed");
        $finish;
    end

endmodule

// File: dv/pipeCore_asserts.sv
`timescale 1ns/1ps

module pipeCore_asserts import corePkg::*; (
    input logic  iClk,
    input logic  iRst_n,
    input word_t instAddr,
    input logic  memWrite
);

    // Failed assertions, read by the testbench at the end of the run
    int failCount = 0;

    memWriteKnown: assert property (
        @(posedge iClk) disable iff (!iRst_n) !$isunknown(memWrite)
    ) else begin
        failCount++;
        $error("memWrite is unknown after reset");
    end

    pcAligned: assert property (
        @(posedge iClk) disable iff (!iRst_n) instAddr[1:0] == 2'b00
    ) else begin
        failCount++;
        $error("instAddr %h is not word aligned", instAddr);
    end

    // One fetch per cycle without stalls
    pcStep: assert property (
        @(posedge iClk) disable iff (!iRst_n)
        $past(iRst_n) |-> instAddr == $past(instAddr) + 32'd4
    ) else begin
        failCount++;
        $error("instAddr did not advance by 4");
    end

    // Pipeline still filling
    noEarlyStore: assert property (
        @(posedge iClk) disable iff (!iRst_n)
        $rose(iRst_n) |-> !memWrite [*3]
    ) else begin
        failCount++;
        $error("memWrite high within three cycles of reset");
    end

endmodule

bind pipeCore pipeCore_asserts uAsserts (
    .iClk     (iClk),
    .iRst_n   (iRst_n),
    .instAddr (instAddr),
    .memWrite (memWrite)
);

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import corePkg::*; (
    input  word_t    a,
    input  word_t    b,
    input  aluCtrl_t ctrl,
    input  logic     signedOp,
    output word_t    result
);

    shamt_t amount;
    logic   lessThan;

    // Shift amount comes from a, the shifted value is b
    assign amount = a[4:0];

    assign lessThan = signedOp ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (ctrl)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluNor:  result = ~(a | b);
            AluSll:  result = b << amount;
            AluSrl:  result = b >> amount;
            AluSra:  result = word_t'($signed(b) >>> amount);
            AluSlt:  result = {{(LinkWidth-1){1'b0}}, lessThan};
            AluLui:  result = {b[LinkWidth/2-1:0], {(LinkWidth/2){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

// File: logic/corePkg.sv
package corePkg;

    localparam int LinkWidth = 32;

    typedef logic [LinkWidth-1:0] word_t;
    typedef logic [4:0]           regId_t;
    typedef logic [5:0]           opcode_t;
    typedef logic [5:0]           funct_t;
    typedef logic [4:0]           shamt_t;
    typedef logic [3:0]           aluCtrl_t;

    // ALU operation selectors
    localparam aluCtrl_t AluAdd = 4'd0;
    localparam aluCtrl_t AluSub = 4'd1;
    localparam aluCtrl_t AluAnd = 4'd2;
    localparam aluCtrl_t AluOr  = 4'd3;
    localparam aluCtrl_t AluXor = 4'd4;
    localparam aluCtrl_t AluNor = 4'd5;
    localparam aluCtrl_t AluSll = 4'd6;
    localparam aluCtrl_t AluSrl = 4'd7;
    localparam aluCtrl_t AluSra = 4'd8;
    localparam aluCtrl_t AluSlt = 4'd9;
    localparam aluCtrl_t AluLui = 4'd10;

    // Primary opcodes
    localparam opcode_t OpRType = 6'h00;
    localparam opcode_t OpAddi  = 6'h08;
    localparam opcode_t OpAddiu = 6'h09;
    localparam opcode_t OpSlti  = 6'h0a;
    localparam opcode_t OpSltiu = 6'h0b;
    localparam opcode_t OpAndi  = 6'h0c;
    localparam opcode_t OpOri   = 6'h0d;
    localparam opcode_t OpLui   = 6'h0f;
    localparam opcode_t OpSw    = 6'h2b;

    // R-type function codes
    localparam funct_t FunctSll  = 6'h00;
    localparam funct_t FunctSrl  = 6'h02;
    localparam funct_t FunctSra  = 6'h03;
    localparam funct_t FunctSllv = 6'h04;
    localparam funct_t FunctSrlv = 6'h06;
    localparam funct_t FunctSrav = 6'h07;
    localparam funct_t FunctAdd  = 6'h20;
    localparam funct_t FunctAddu = 6'h21;
    localparam funct_t FunctSub  = 6'h22;
    localparam funct_t FunctSubu = 6'h23;
    localparam funct_t FunctAnd  = 6'h24;
    localparam funct_t FunctOr   = 6'h25;
    localparam funct_t FunctXor  = 6'h26;
    localparam funct_t FunctNor  = 6'h27;
    localparam funct_t FunctSlt  = 6'h2a;

endpackage

// File: logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import corePkg::*; #(
    parameter word_t ResetPc = '0
) (
    input  logic   iClk,
    input  logic   iRst_n,
    output word_t  instAddr,
    input  word_t  inst,
    idExIf.decode  idEx,
    input  logic   wbRegWrite,
    input  regId_t wbRegId,
    input  word_t  wbData
);

    word_t    pc;
    word_t    ifIdInst;
    logic     ifIdValid;
    aluCtrl_t decAluCtrl;
    logic     decAluSigned;
    logic     decUseShamt;
    logic     decUseImm;
    word_t    decImm;
    regId_t   decWrRegId;
    logic     decRegWrite;
    logic     decMemWrite;
    regId_t   rsId;
    regId_t   rtId;
    word_t    rsData;
    word_t    rtData;

    assign instAddr = pc;
    assign rsId     = ifIdInst[25:21];
    assign rtId     = ifIdInst[20:16];

    // Fetch and IF/ID
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            pc        <= ResetPc;
            ifIdInst  <= '0;
            ifIdValid <= 1'b0;
        end else begin
            pc        <= pc + 32'd4;
            ifIdInst  <= inst;
            ifIdValid <= 1'b1;
        end
    end

    instDecoder uDecoder (
        .inst      (ifIdInst),
        .aluCtrl   (decAluCtrl),
        .aluSigned (decAluSigned),
        .useShamt  (decUseShamt),
        .useImm    (decUseImm),
        .imm       (decImm),
        .wrRegId   (decWrRegId),
        .regWrite  (decRegWrite),
        .memWrite  (decMemWrite)
    );

    regFile uRegFile (
        .iClk    (iClk),
        .iRst_n  (iRst_n),
        .rdIdA   (rsId),
        .rdDataA (rsData),
        .rdIdB   (rtId),
        .rdDataB (rtData),
        .wrEn    (wbRegWrite),
        .wrId    (wbRegId),
        .wrData  (wbData)
    );

    // ID/EX register
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            idEx.valid     <= 1'b0;
            idEx.aluCtrl   <= AluAdd;
            idEx.aluSigned <= 1'b0;
            idEx.useShamt  <= 1'b0;
            idEx.shamt     <= '0;
            idEx.useImm    <= 1'b0;
            idEx.imm       <= '0;
            idEx.rsId      <= '0;
            idEx.rtId      <= '0;
            idEx.rsData    <= '0;
            idEx.rtData    <= '0;
            idEx.wrRegId   <= '0;
            idEx.regWrite  <= 1'b0;
            idEx.memWrite  <= 1'b0;
        end else begin
            idEx.valid     <= ifIdValid;
            idEx.aluCtrl   <= decAluCtrl;
            idEx.aluSigned <= decAluSigned;
            idEx.useShamt  <= decUseShamt;
            idEx.shamt     <= ifIdInst[10:6];
            idEx.useImm    <= decUseImm;
            idEx.imm       <= decImm;
            idEx.rsId      <= rsId;
            idEx.rtId      <= rtId;
            idEx.rsData    <= rsData;
            idEx.rtData    <= rtData;
            idEx.wrRegId   <= decWrRegId;
            idEx.regWrite  <= decRegWrite;
            idEx.memWrite  <= decMemWrite;
        end
    end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/1ps

module executeStage import corePkg::*; (
    input  logic    iClk,
    input  logic    iRst_n,
    idExIf.execute  idEx,
    output logic    memWrite,
    output word_t   memAddr,
    output word_t   memWrData,
    output logic    wbRegWrite,
    output regId_t  wbRegId,
    output word_t   wbData
);

    word_t  rsFwd;
    word_t  rtFwd;
    word_t  opA;
    word_t  opB;
    word_t  aluResult;

    word_t  exMemResult;
    word_t  exMemStoreData;
    regId_t exMemRegId;
    logic   exMemRegWrite;
    logic   exMemMemWrite;

    word_t  memWbResult;
    regId_t memWbRegId;
    logic   memWbRegWrite;

    // Youngest producer wins, then the older one, then the register read
    function automatic word_t forward(regId_t id, word_t regVal);
        if (exMemRegWrite && (exMemRegId == id)) begin
            return exMemResult;
        end
        if (memWbRegWrite && (memWbRegId == id)) begin
            return memWbResult;
        end
        return regVal;
    endfunction

    always_comb begin
        rsFwd = forward(idEx.rsId, idEx.rsData);
        rtFwd = forward(idEx.rtId, idEx.rtData);
    end

    assign opA = idEx.useShamt ? {{(LinkWidth-5){1'b0}}, idEx.shamt} : rsFwd;
    assign opB = idEx.useImm   ? idEx.imm : rtFwd;

    alu uAlu (
        .a        (opA),
        .b        (opB),
        .ctrl     (idEx.aluCtrl),
        .signedOp (idEx.aluSigned),
        .result   (aluResult)
    );

    // EX/MEM
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            exMemResult    <= '0;
            exMemStoreData <= '0;
            exMemRegId     <= '0;
            exMemRegWrite  <= 1'b0;
            exMemMemWrite  <= 1'b0;
        end else begin
            exMemResult    <= aluResult;
            // Store data sees the same forwarding as the ALU operands
            exMemStoreData <= rtFwd;
            exMemRegId     <= idEx.wrRegId;
            exMemRegWrite  <= idEx.valid && idEx.regWrite;
            exMemMemWrite  <= idEx.valid && idEx.memWrite;
        end
    end

    assign memWrite  = exMemMemWrite;
    assign memAddr   = exMemResult;
    assign memWrData = exMemStoreData;

    // MEM/WB, no load path so the ALU result is carried as is
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            memWbResult   <= '0;
            memWbRegId    <= '0;
            memWbRegWrite <= 1'b0;
        end else begin
            memWbResult   <= exMemResult;
            memWbRegId    <= exMemRegId;
            memWbRegWrite <= exMemRegWrite;
        end
    end

    assign wbRegWrite = memWbRegWrite;
    assign wbRegId    = memWbRegId;
    assign wbData     = memWbResult;

endmodule

// File: logic/idExIf.sv
`timescale 1ns/1ps

interface idExIf import corePkg::*; ();

    logic     valid;
    aluCtrl_t aluCtrl;
    logic     aluSigned;
    logic     useShamt;
    shamt_t   shamt;
    logic     useImm;
    word_t    imm;
    regId_t   rsId;
    regId_t   rtId;
    word_t    rsData;
    word_t    rtData;
    regId_t   wrRegId;
    logic     regWrite;
    logic     memWrite;

    modport decode (
        output valid, aluCtrl, aluSigned, useShamt, shamt, useImm, imm,
               rsId, rtId, rsData, rtData, wrRegId, regWrite, memWrite
    );

    modport execute (
        input valid, aluCtrl, aluSigned, useShamt, shamt, useImm, imm,
              rsId, rtId, rsData, rtData, wrRegId, regWrite, memWrite
    );

endinterface

// File: logic/instDecoder.sv
`timescale 1ns/1ps

module instDecoder import corePkg::*; (
    input  word_t    inst,
    output aluCtrl_t aluCtrl,
    output logic     aluSigned,
    output logic     useShamt,
    output logic     useImm,
    output word_t    imm,
    output regId_t   wrRegId,
    output logic     regWrite,
    output logic     memWrite
);

    opcode_t opcode;
    funct_t  funct;
    regId_t  rtField;
    regId_t  rdField;
    logic    zeroExt;
    logic    writesReg;

    assign opcode  = inst[31:26];
    assign rtField = inst[20:16];
    assign rdField = inst[15:11];
    assign funct   = inst[5:0];

    // Logical immediates zero-extend, everything else sign-extends
    assign imm = zeroExt ? {{(LinkWidth-16){1'b0}}, inst[15:0]}
                         : {{(LinkWidth-16){inst[15]}}, inst[15:0]};

    // r0 is never a real destination
    assign regWrite = writesReg && (wrRegId != '0);

    always_comb begin
        aluCtrl   = AluAdd;
        aluSigned = 1'b0;
        useShamt  = 1'b0;
        useImm    = 1'b1;
        zeroExt   = 1'b0;
        wrRegId   = rtField;
        writesReg = 1'b0;
        memWrite  = 1'b0;
        case (opcode)
            OpRType: begin
                useImm    = 1'b0;
                wrRegId   = rdField;
                writesReg = 1'b1;
                case (funct)
                    FunctAdd, FunctAddu: aluCtrl = AluAdd;
                    FunctSub, FunctSubu: aluCtrl = AluSub;
                    FunctAnd:            aluCtrl = AluAnd;
                    FunctOr:             aluCtrl = AluOr;
                    FunctXor:            aluCtrl = AluXor;
                    FunctNor:            aluCtrl = AluNor;
                    FunctSlt:            aluCtrl = AluSlt;
                    FunctSll, FunctSllv: aluCtrl = AluSll;
                    FunctSrl, FunctSrlv: aluCtrl = AluSrl;
                    FunctSra, FunctSrav: aluCtrl = AluSra;
                    default:             writesReg = 1'b0;
                endcase
                aluSigned = funct inside {FunctAdd, FunctSub, FunctSlt};
                // Fixed shifts take the amount from the shamt field
                useShamt  = funct inside {FunctSll, FunctSrl, FunctSra};
            end
            OpAddi: begin
                aluSigned = 1'b1;
                writesReg = 1'b1;
            end
            OpAddiu: writesReg = 1'b1;
            OpAndi: begin
                aluCtrl   = AluAnd;
                zeroExt   = 1'b1;
                writesReg = 1'b1;
            end
            OpOri: begin
                aluCtrl   = AluOr;
                zeroExt   = 1'b1;
                writesReg = 1'b1;
            end
            OpSlti: begin
                aluCtrl   = AluSlt;
                aluSigned = 1'b1;
                writesReg = 1'b1;
            end
            OpSltiu: begin
                aluCtrl   = AluSlt;
                writesReg = 1'b1;
            end
            OpLui: begin
                aluCtrl   = AluLui;
                writesReg = 1'b1;
            end
            // Address is rs plus offset, data comes from rt
            OpSw:    memWrite = 1'b1;
            default: writesReg = 1'b0;
        endcase
    end

endmodule

// File: logic/pipeCore.sv
`timescale 1ns/1ps

module pipeCore import corePkg::*; #(
    parameter word_t ResetPc = 32'h0040_00a8
) (
    input  logic  iClk,
    input  logic  iRst_n,
    output word_t instAddr,
    input  word_t inst,
    output logic  memWrite,
    output word_t memAddr,
    output word_t memWrData
);

    logic   wbRegWrite;
    regId_t wbRegId;
    word_t  wbData;

    idExIf idEx ();

    // Fetch and decode, holds the PC and the register file
    decodeStage #(
        .ResetPc (ResetPc)
    ) uDecode (
        .iClk       (iClk),
        .iRst_n     (iRst_n),
        .instAddr   (instAddr),
        .inst       (inst),
        .idEx       (idEx.decode),
        .wbRegWrite (wbRegWrite),
        .wbRegId    (wbRegId),
        .wbData     (wbData)
    );

    executeStage uExecute (
        .iClk       (iClk),
        .iRst_n     (iRst_n),
        .idEx       (idEx.execute),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memWrData  (memWrData),
        .wbRegWrite (wbRegWrite),
        .wbRegId    (wbRegId),
        .wbData     (wbData)
    );

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile import corePkg::*; (
    input  logic   iClk,
    input  logic   iRst_n,
    input  regId_t rdIdA,
    output word_t  rdDataA,
    input  regId_t rdIdB,
    output word_t  rdDataB,
    input  logic   wrEn,
    input  regId_t wrId,
    input  word_t  wrData
);

    word_t regs [32];

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrId != '0)) begin
            regs[wrId] <= wrData;
        end
    end

    // Same-cycle write passes straight through to the readers
    assign rdDataA = (rdIdA == '0)                 ? '0     :
                     (wrEn && (wrId == rdIdA))     ? wrData :
                                                     regs[rdIdA];
    assign rdDataB = (rdIdB == '0)                 ? '0     :
                     (wrEn && (wrId == rdIdB))     ? wrData :
                                                     regs[rdIdB];

endmodule
